// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int WORD_W = 16;
    localparam int ADDR_W = 9;
    localparam int NUM_REGS = 8;
    localparam int REG_IDX_W = $clog2(NUM_REGS);

    // Instruction field positions
    localparam int OPCODE_LSB = 13;
    localparam int OP_LSB = 11;
    localparam int RN_LSB = 8;
    localparam int RD_LSB = 5;
    localparam int SHIFT_LSB = 3;
    localparam int RM_LSB = 0;
    localparam int IMM8_W = 8;
    localparam int IMM5_W = 5;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        OPC_LDR  = 3'b011,
        OPC_STR  = 3'b100,
        OPC_ALU  = 3'b101,
        OPC_MOV  = 3'b110,
        OPC_HALT = 3'b111
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01, // CMP
        ALU_AND = 2'b10,
        ALU_NOT = 2'b11  // MVN
    } alu_op_e;

    typedef enum logic [1:0] {
        SH_NONE = 2'b00,
        SH_LSL  = 2'b01,
        SH_LSR  = 2'b10,
        SH_ASR  = 2'b11
    } shift_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_WRITE = 2'b01,
        MEM_READ  = 2'b10
    } mem_cmd_e;

    typedef enum logic [1:0] {SEL_RN, SEL_RD, SEL_RM} reg_sel_e;

    typedef enum logic [1:0] {WB_MEM, WB_IMM, WB_ALU} wb_sel_e;

    typedef enum logic [3:0] {
        ST_RESET, ST_IF1, ST_IF2, ST_UPDATE_PC, ST_DECODE,
        ST_GET_A, ST_GET_B, ST_EXEC,
        ST_ADDR, ST_MEM_RD, ST_STORE_DATA, ST_MEM_WR,
        ST_WRITE_REG, ST_HALT
    } state_e;

endpackage

`default_nettype wire

// ==== src/ctrl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface ctrl_if;
    import cpu_pkg::*;

    logic load_a;
    logic load_b;
    logic load_c;
    logic load_status;
    logic a_zero;      // Force ALU input A to zero
    logic b_imm;       // Take sximm5 in place of shifted B
    logic reg_write;
    reg_sel_e reg_sel;
    wb_sel_e wb_sel;
    alu_op_e alu_op;

    modport controller (
        output load_a, load_b, load_c, load_status,
        output a_zero, b_imm,
        output reg_write, reg_sel, wb_sel, alu_op
    );

    modport datapath (
        input load_a, load_b, load_c, load_status,
        input a_zero, b_imm,
        input reg_write, wb_sel, alu_op
    );

    modport decoder (input reg_sel);

endinterface

`default_nettype wire

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  logic              clk,
    input  cpu_pkg::word_t    read_data,
    input  logic              load_ir,
    ctrl_if.decoder           ctrl,
    output cpu_pkg::opcode_e  opcode,
    output logic [1:0]        op,
    output cpu_pkg::shift_e   shift,
    output cpu_pkg::reg_idx_t reg_idx,
    output cpu_pkg::word_t    sximm5,
    output cpu_pkg::word_t    sximm8
);
    import cpu_pkg::*;

    word_t ir;
    reg_idx_t rn;
    reg_idx_t rd;
    reg_idx_t rm;

    always_ff @(posedge clk) begin
        if (load_ir) begin
            ir <= read_data;
        end
    end

    assign opcode = opcode_e'(ir[OPCODE_LSB +: $bits(opcode_e)]);
    assign op = ir[OP_LSB +: 2];
    assign rn = ir[RN_LSB +: REG_IDX_W];
    assign rd = ir[RD_LSB +: REG_IDX_W];
    assign rm = ir[RM_LSB +: REG_IDX_W];

    // STR data goes to memory unshifted; the field overlaps imm5
    assign shift = (opcode == OPC_STR) ? SH_NONE : shift_e'(ir[SHIFT_LSB +: $bits(shift_e)]);

    assign sximm8 = {{(WORD_W - IMM8_W){ir[IMM8_W-1]}}, ir[IMM8_W-1:0]};
    assign sximm5 = {{(WORD_W - IMM5_W){ir[IMM5_W-1]}}, ir[IMM5_W-1:0]};

    always_comb begin
        case (ctrl.reg_sel)
            SEL_RD:  reg_idx = rd;
            SEL_RM:  reg_idx = rm;
            default: reg_idx = rn;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module controller (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::opcode_e  opcode,
    input  logic [1:0]        op,
    ctrl_if.controller        ctrl,
    output logic              load_ir,
    output logic              load_pc,
    output logic              load_addr,
    output logic              use_pc,
    output cpu_pkg::mem_cmd_e mem_cmd,
    output logic              halted
);
    import cpu_pkg::*;

    state_e state;
    state_e next_state;
    alu_op_e alu_fn;
    logic is_mov_imm;
    logic is_mvn;
    logic is_cmp;

    assign alu_fn = alu_op_e'(op);
    assign is_mov_imm = (opcode == OPC_MOV) && (op == 2'b10);
    assign is_mvn = (opcode == OPC_ALU) && (alu_fn == ALU_NOT);
    assign is_cmp = (opcode == OPC_ALU) && (alu_fn == ALU_SUB);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        ctrl.load_a = 1'b0;
        ctrl.load_b = 1'b0;
        ctrl.load_c = 1'b0;
        ctrl.load_status = 1'b0;
        ctrl.a_zero = 1'b0;
        ctrl.b_imm = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.reg_sel = SEL_RN;
        ctrl.wb_sel = WB_ALU;
        ctrl.alu_op = ALU_ADD;
        load_ir = 1'b0;
        load_pc = 1'b0;
        load_addr = 1'b0;
        use_pc = 1'b0;
        mem_cmd = MEM_NONE;
        halted = 1'b0;

        case (state)
            ST_RESET: next_state = ST_IF1;
            ST_IF1: begin
                use_pc = 1'b1;
                mem_cmd = MEM_READ;
                next_state = ST_IF2;
            end
            ST_IF2: begin
                use_pc = 1'b1;
                mem_cmd = MEM_READ;
                load_ir = 1'b1; // Word from IF1 is on read_data now
                next_state = ST_UPDATE_PC;
            end
            ST_UPDATE_PC: begin
                load_pc = 1'b1;
                next_state = ST_DECODE;
            end
            ST_DECODE: begin
                case (opcode)
                    OPC_MOV:          next_state = is_mov_imm ? ST_WRITE_REG : ST_GET_B;
                    OPC_ALU:          next_state = is_mvn ? ST_GET_B : ST_GET_A;
                    OPC_LDR, OPC_STR: next_state = ST_GET_A;
                    default:          next_state = ST_HALT; // HALT and unused opcodes
                endcase
            end
            ST_GET_A: begin
                ctrl.reg_sel = SEL_RN;
                ctrl.load_a = 1'b1;
                next_state = (opcode == OPC_ALU) ? ST_GET_B : ST_ADDR;
            end
            ST_GET_B: begin
                ctrl.reg_sel = (opcode == OPC_STR) ? SEL_RD : SEL_RM;
                ctrl.load_b = 1'b1;
                // C still holds base plus offset for STR
                load_addr = (opcode == OPC_STR);
                next_state = (opcode == OPC_STR) ? ST_STORE_DATA : ST_EXEC;
            end
            ST_EXEC: begin
                ctrl.a_zero = (opcode == OPC_MOV); // MOV passes shifted B
                ctrl.alu_op = (opcode == OPC_MOV) ? ALU_ADD : alu_fn;
                if (is_cmp) begin
                    ctrl.load_status = 1'b1;
                    next_state = ST_IF1;
                end else begin
                    ctrl.load_c = 1'b1;
                    next_state = ST_WRITE_REG;
                end
            end
            ST_ADDR: begin
                ctrl.b_imm = 1'b1;
                ctrl.load_c = 1'b1;
                next_state = (opcode == OPC_LDR) ? ST_MEM_RD : ST_GET_B;
            end
            ST_MEM_RD: begin
                load_addr = 1'b1;
                mem_cmd = MEM_READ;
                next_state = ST_WRITE_REG;
            end
            ST_STORE_DATA: begin
                ctrl.a_zero = 1'b1;
                ctrl.load_c = 1'b1;
                next_state = ST_MEM_WR;
            end
            ST_MEM_WR: begin
                mem_cmd = MEM_WRITE;
                next_state = ST_IF1;
            end
            ST_WRITE_REG: begin
                ctrl.reg_write = 1'b1;
                if (is_mov_imm) begin
                    ctrl.reg_sel = SEL_RN;
                    ctrl.wb_sel = WB_IMM;
                end else if (opcode == OPC_LDR) begin
                    ctrl.reg_sel = SEL_RD;
                    ctrl.wb_sel = WB_MEM;
                    mem_cmd = MEM_READ; // Hold the read issued in MEM_RD
                end else begin
                    ctrl.reg_sel = SEL_RD;
                end
                next_state = ST_IF1;
            end
            ST_HALT: halted = 1'b1; // Only reset leaves
            default: next_state = ST_RESET;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic              clk,
    input  logic              write,
    input  cpu_pkg::reg_idx_t idx,
    input  cpu_pkg::word_t    data_in,
    output cpu_pkg::word_t    data_out
);
    import cpu_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (write) begin
            regs[idx] <= data_in;
        end
    end

    // Same index serves the read and the write
    assign data_out = regs[idx];

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath (
    input  logic              clk,
    ctrl_if.datapath          ctrl,
    input  cpu_pkg::word_t    read_data,
    input  cpu_pkg::word_t    sximm5,
    input  cpu_pkg::word_t    sximm8,
    input  cpu_pkg::shift_e   shift,
    input  cpu_pkg::reg_idx_t reg_idx,
    output cpu_pkg::word_t    c_out,
    output logic              n,
    output logic              v,
    output logic              z
);
    import cpu_pkg::*;

    word_t wb_data;
    word_t rf_out;
    word_t a_reg;
    word_t b_reg;
    word_t b_shifted;
    word_t alu_a;
    word_t alu_b;
    word_t alu_out;
    logic alu_v;

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = read_data;
            WB_IMM:  wb_data = sximm8;
            default: wb_data = c_out;
        endcase
    end

    regfile u_regfile (
        .clk      (clk),
        .write    (ctrl.reg_write),
        .idx      (reg_idx),
        .data_in  (wb_data),
        .data_out (rf_out)
    );

    always_ff @(posedge clk) begin
        if (ctrl.load_a) begin
            a_reg <= rf_out;
        end
        if (ctrl.load_b) begin
            b_reg <= rf_out;
        end
        if (ctrl.load_c) begin
            c_out <= alu_out;
        end
        if (ctrl.load_status) begin
            z <= (alu_out == '0);
            n <= alu_out[WORD_W-1];
            v <= alu_v;
        end
    end

    always_comb begin
        case (shift)
            SH_LSL:  b_shifted = {b_reg[WORD_W-2:0], 1'b0};
            SH_LSR:  b_shifted = {1'b0, b_reg[WORD_W-1:1]};
            SH_ASR:  b_shifted = {b_reg[WORD_W-1], b_reg[WORD_W-1:1]};
            default: b_shifted = b_reg;
        endcase
    end

    assign alu_a = ctrl.a_zero ? '0 : a_reg;
    assign alu_b = ctrl.b_imm ? sximm5 : b_shifted;

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB: alu_out = alu_a - alu_b;
            ALU_AND: alu_out = alu_a & alu_b;
            ALU_NOT: alu_out = ~alu_b;
            default: alu_out = alu_a + alu_b;
        endcase
    end

    // Signs of A and B differ and the result's sign differs from A
    assign alu_v = (alu_a[WORD_W-1] != alu_b[WORD_W-1])
                   && (alu_out[WORD_W-1] != alu_a[WORD_W-1]);

endmodule

`default_nettype wire

// ==== src/pc_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module pc_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           load_pc,
    input  logic           load_addr,
    input  logic           use_pc,
    input  cpu_pkg::addr_t c_low,
    output cpu_pkg::addr_t mem_addr
);
    import cpu_pkg::*;

    addr_t pc;
    addr_t data_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (load_pc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_addr) begin
            data_addr <= c_low;
        end
    end

    // LDR reads in the same cycle the address register captures C
    always_comb begin
        if (use_pc) begin
            mem_addr = pc;
        end else if (load_addr) begin
            mem_addr = c_low;
        end else begin
            mem_addr = data_addr;
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::word_t    read_data,
    output cpu_pkg::mem_cmd_e mem_cmd,
    output cpu_pkg::addr_t    mem_addr,
    output cpu_pkg::word_t    write_data,
    output logic              n,
    output logic              v,
    output logic              z,
    output logic              halted
);
    import cpu_pkg::*;

    opcode_e opcode;
    logic [1:0] op;
    shift_e shift;
    reg_idx_t reg_idx;
    word_t sximm5;
    word_t sximm8;
    logic load_ir;
    logic load_pc;
    logic load_addr;
    logic use_pc;

    ctrl_if ctrl ();

    instr_decoder u_decoder (
        .clk       (clk),
        .read_data (read_data),
        .load_ir   (load_ir),
        .ctrl      (ctrl),
        .opcode    (opcode),
        .op        (op),
        .shift     (shift),
        .reg_idx   (reg_idx),
        .sximm5    (sximm5),
        .sximm8    (sximm8)
    );

    controller u_controller (
        .clk       (clk),
        .reset     (reset),
        .opcode    (opcode),
        .op        (op),
        .ctrl      (ctrl),
        .load_ir   (load_ir),
        .load_pc   (load_pc),
        .load_addr (load_addr),
        .use_pc    (use_pc),
        .mem_cmd   (mem_cmd),
        .halted    (halted)
    );

    datapath u_datapath (
        .clk       (clk),
        .ctrl      (ctrl),
        .read_data (read_data),
        .sximm5    (sximm5),
        .sximm8    (sximm8),
        .shift     (shift),
        .reg_idx   (reg_idx),
        .c_out     (write_data), // C drives the store data
        .n         (n),
        .v         (v),
        .z         (z)
    );

    pc_unit u_pc_unit (
        .clk       (clk),
        .reset     (reset),
        .load_pc   (load_pc),
        .load_addr (load_addr),
        .use_pc    (use_pc),
        .c_low     (write_data[ADDR_W-1:0]),
        .mem_addr  (mem_addr)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_cases.svh ====
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

typedef enum logic [2:0] {
    K_MOVI,
    K_MOVR,
    K_ADD,
    K_AND,
    K_MVN,
    K_LDR
} op_kind_e;

typedef struct packed {
    op_kind_e   kind;
    logic [7:0] a;
    logic [7:0] b;
    shift_e     sh;
    word_t      data; // LDR rows only
} case_t;

// Kind, operand a, operand b, shift on the second operand, LDR data word
localparam case_t FIXED_CASES [16] = '{
    '{K_MOVI, 8'h05, 8'h03, SH_NONE, 16'h0000},
    '{K_MOVI, 8'h80, 8'h7f, SH_NONE, 16'h0000},
    '{K_MOVR, 8'h81, 8'h01, SH_NONE, 16'h0000},
    '{K_MOVR, 8'h81, 8'h01, SH_LSL,  16'h0000},
    '{K_MOVR, 8'h81, 8'h01, SH_LSR,  16'h0000},
    '{K_MOVR, 8'h81, 8'h01, SH_ASR,  16'h0000},
    '{K_ADD,  8'h7f, 8'h01, SH_NONE, 16'h0000},
    '{K_ADD,  8'h10, 8'hf0, SH_LSL,  16'h0000},
    '{K_AND,  8'h3c, 8'h0f, SH_NONE, 16'h0000},
    '{K_AND,  8'hf0, 8'haa, SH_ASR,  16'h0000},
    '{K_MVN,  8'h00, 8'h55, SH_NONE, 16'h0000},
    '{K_MVN,  8'h00, 8'h80, SH_LSR,  16'h0000},
    '{K_LDR,  8'h00, 8'h01, SH_NONE, 16'h8000}, // Negative overflow on CMP
    '{K_LDR,  8'h00, 8'hff, SH_NONE, 16'h7fff}, // Positive overflow on CMP
    '{K_LDR,  8'h00, 8'h34, SH_NONE, 16'h0034},
    '{K_MOVI, 8'h22, 8'h22, SH_NONE, 16'h0000}
};

function automatic word_t mov_imm_word(input reg_idx_t rn, input logic [7:0] imm8);
    return {OPC_MOV, 2'b10, rn, imm8};
endfunction

function automatic word_t mov_reg_word(input reg_idx_t rd, input reg_idx_t rm,
                                       input shift_e sh);
    return {OPC_MOV, 2'b00, 3'b000, rd, sh, rm};
endfunction

function automatic word_t alu_word(input alu_op_e fn, input reg_idx_t rn, input reg_idx_t rd,
                                   input shift_e sh, input reg_idx_t rm);
    return {OPC_ALU, fn, rn, rd, sh, rm};
endfunction

function automatic word_t load_word(input reg_idx_t rn, input reg_idx_t rd,
                                    input logic [4:0] imm5);
    return {OPC_LDR, 2'b00, rn, rd, imm5};
endfunction

function automatic word_t store_word(input reg_idx_t rn, input reg_idx_t rd,
                                     input logic [4:0] imm5);
    return {OPC_STR, 2'b00, rn, rd, imm5};
endfunction

function automatic word_t halt_word();
    return {OPC_HALT, 13'b0};
endfunction

`endif

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam int ROW_CYCLES = 100; // Longest program is about 70 cycles with reset
    localparam int HALT_LIMIT = 150;
    localparam int PROG_LEN = 9;
    localparam int RANDOM_ROWS = 6;
    localparam addr_t RESULT_ADDR = 9'd256;
    localparam addr_t SECOND_ADDR = 9'd265;
    localparam addr_t LOAD_ADDR = 9'd261;

    `include "tb_cases.svh"

    logic clk;
    logic reset;
    word_t read_data;
    mem_cmd_e mem_cmd;
    addr_t mem_addr;
    word_t write_data;
    logic n;
    logic v;
    logic z;
    logic halted;

    word_t mem [512];
    word_t read_buf;
    case_t cases [$];
    addr_t fetch_log [$];
    addr_t write_addr_log [$];
    word_t write_data_log [$];
    logic prev_read;
    addr_t prev_addr;
    logic cases_ready;
    int value_errors;
    int other_errors;

    cpu DUT (
        .clk        (clk),
        .reset      (reset),
        .read_data  (read_data),
        .mem_cmd    (mem_cmd),
        .mem_addr   (mem_addr),
        .write_data (write_data),
        .n          (n),
        .v          (v),
        .z          (z),
        .halted     (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected) begin
            value_errors++;
            $display("[FAIL] %0t ns: %s got %h, expected %h", $time, name, got, expected);
        end
    endtask

    // Registered read with data handed to the DUT on the falling edge
    always @(posedge clk) begin
        if (mem_cmd == MEM_READ) begin
            read_buf <= mem[mem_addr];
        end else if (mem_cmd == MEM_WRITE) begin
            mem[mem_addr] = write_data;
            write_addr_log.push_back(mem_addr);
            write_data_log.push_back(write_data);
        end
    end

    always @(negedge clk) begin
        read_data <= read_buf;
    end

    // Program lives below 256, so a new read there is a fetch
    always @(posedge clk) begin
        if (reset) begin
            prev_read <= 1'b0;
        end else begin
            if (mem_cmd == MEM_READ && mem_addr < RESULT_ADDR
                && !(prev_read && prev_addr == mem_addr)) begin
                fetch_log.push_back(mem_addr);
            end
            prev_read <= (mem_cmd == MEM_READ);
            prev_addr <= mem_addr;
        end
        if (halted) begin
            check_value("mem_cmd while halted", 16'(mem_cmd), 16'(MEM_NONE));
        end
    end

    function automatic word_t sext8(input logic [7:0] x);
        return {{8{x[7]}}, x};
    endfunction

    function automatic word_t shifted(input word_t x, input shift_e sh);
        case (sh)
            SH_LSL:  return x << 1;
            SH_LSR:  return x >> 1;
            SH_ASR:  return word_t'($signed(x) >>> 1);
            default: return x;
        endcase
    endfunction

    function automatic word_t expected_result(input case_t c);
        case (c.kind)
            K_MOVI:  return sext8(c.a);
            K_MOVR:  return shifted(sext8(c.a), c.sh);
            K_ADD:   return sext8(c.a) + shifted(sext8(c.b), c.sh);
            K_AND:   return sext8(c.a) & shifted(sext8(c.b), c.sh);
            K_MVN:   return ~shifted(sext8(c.b), c.sh);
            default: return c.data;
        endcase
    endfunction

    // Flags of lhs minus rhs with overflow from the exact signed difference
    task automatic check_flags(input word_t lhs, input word_t rhs);
        int diff;
        word_t low;
        diff = int'($signed(lhs)) - int'($signed(rhs));
        low = word_t'(diff);
        check_value("z", 16'(z), 16'(low == 16'h0));
        check_value("n", 16'(n), 16'(low[15]));
        check_value("v", 16'(v), 16'(diff > 32767 || diff < -32768));
    endtask

    task automatic load_program(input case_t c);
        int i;
        word_t op_word;
        for (i = 0; i < 512; i++) begin
            mem[i] = 16'h5a00 ^ 16'(i);
        end
        case (c.kind)
            K_MOVI:  op_word = mov_imm_word(3'd2, c.a);
            K_MOVR:  op_word = mov_reg_word(3'd2, 3'd0, c.sh);
            K_ADD:   op_word = alu_word(ALU_ADD, 3'd0, 3'd2, c.sh, 3'd1);
            K_AND:   op_word = alu_word(ALU_AND, 3'd0, 3'd2, c.sh, 3'd1);
            K_MVN:   op_word = alu_word(ALU_NOT, 3'd0, 3'd2, c.sh, 3'd1);
            default: op_word = load_word(3'd7, 3'd2, 5'd5);
        endcase
        mem[0] = mov_imm_word(3'd0, c.a);
        mem[1] = mov_imm_word(3'd1, c.b);
        mem[2] = mov_imm_word(3'd7, 8'h80);
        mem[3] = mov_reg_word(3'd7, 3'd7, SH_LSL); // R7 = 0xff00 so its low bits give 256
        mem[4] = op_word;
        mem[5] = store_word(3'd7, 3'd2, 5'd0);
        mem[6] = alu_word(ALU_SUB, 3'd2, 3'd0, SH_NONE, 3'd1); // CMP R2, R1
        mem[7] = store_word(3'd7, 3'd1, 5'd9); // Offset bits 4:3 land in the shift field
        mem[8] = halt_word();
        if (c.kind == K_LDR) begin
            mem[LOAD_ADDR] = c.data;
        end
    endtask

    task automatic apply_reset(input case_t c);
        @(negedge clk);
        reset = 1'b1;
        load_program(c);
        repeat (RESET_CYCLES) @(negedge clk);
        check_value("halted in reset", 16'(halted), 16'h0);
        check_value("mem_cmd in reset", 16'(mem_cmd), 16'(MEM_NONE));
        fetch_log.delete();
        write_addr_log.delete();
        write_data_log.delete();
        reset = 1'b0;
    endtask

    task automatic wait_for_halt(output bit ok);
        int cycles;
        cycles = 0;
        while (!halted && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = halted;
    endtask

    task automatic run_case(input int row, input case_t c);
        bit done;
        word_t result;
        apply_reset(c);
        wait_for_halt(done);
        if (!done) begin
            other_errors++;
            $display("Row %0d: the processor did not halt within %0d cycles", row, HALT_LIMIT);
        end else begin
            repeat (4) begin
                @(negedge clk);
                check_value("halted", 16'(halted), 16'h1);
            end
            result = expected_result(c);
            check_value("store count", 16'(write_addr_log.size()), 16'd2);
            if (write_addr_log.size() >= 2) begin
                check_value("result store address", 16'(write_addr_log[0]), 16'(RESULT_ADDR));
                check_value("result store data", write_data_log[0], result);
                check_value("second store address", 16'(write_addr_log[1]), 16'(SECOND_ADDR));
                check_value("second store data", write_data_log[1], sext8(c.b));
            end
            check_flags(result, sext8(c.b));
            check_value("fetch count", 16'(fetch_log.size()), 16'(PROG_LEN));
            foreach (fetch_log[i]) begin
                check_value("fetch address", 16'(fetch_log[i]), 16'(i));
            end
        end
    endtask

    initial begin
        case_t c;
        clk = 1'b0;
        reset = 1'b1;
        read_data = '0;
        read_buf = '0;
        cases_ready = 1'b0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(32'h7f5caffd));
        foreach (FIXED_CASES[i]) begin
            cases.push_back(FIXED_CASES[i]);
        end
        repeat (RANDOM_ROWS) begin
            c.kind = op_kind_e'($urandom % 6);
            c.a = 8'($urandom);
            c.b = 8'($urandom);
            c.sh = shift_e'(2'($urandom));
            c.data = 16'($urandom);
            cases.push_back(c);
        end
        cases_ready = 1'b1;

        foreach (cases[i]) begin
            run_case(i, cases[i]);
        end

        $display("Summary: %0d value mismatches, %0d other failures over %0d rows",
                 value_errors, other_errors, cases.size());
        if (value_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (cases_ready);
        repeat (cases.size() * ROW_CYCLES + 200) @(posedge clk);
        $display("Timeout: the run did not finish within its cycle budget");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu.f ====
+incdir+testbench
src/cpu_pkg.sv
src/ctrl_if.sv
src/instr_decoder.sv
src/controller.sv
src/regfile.sv
src/datapath.sv
src/pc_unit.sv
src/cpu.sv
testbench/tb_cpu.sv

// ==== Makefile ====
TOP = tb_cpu

sim:
	verilator --binary -Wno-fatal --top-module $(TOP) -f cpu.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -x "NO ERRORS"

clean:
	rm -rf obj_dir

.PHONY: sim clean
